// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_conv_row
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/conv_mac.sv ====
`timescale 1ns/1ps

module conv_mac (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cmd_valid,
  input  logic [conv_row_pkg::kernel_w-1:0]   kernel,
  input  logic                                win_valid,
  input  logic [conv_row_pkg::win_w-1:0]      win_pixels,
  output logic                                out_valid,
  output logic signed [conv_row_pkg::sum_w-1:0] out_sum
);

  // kernel held for the whole load
  logic [conv_row_pkg::kernel_w-1:0]          kernel_q;
  logic signed [conv_row_pkg::prod_w-1:0]     prod    [conv_row_pkg::taps];
  logic signed [conv_row_pkg::sum_w-1:0]      row_sum [conv_row_pkg::row_count];
  logic signed [conv_row_pkg::sum_w-1:0]      total;

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      kernel_q <= kernel;
    end
  end

  ////////////////////////////////////////
  // products and adder tree
  ////////////////////////////////////////

  // pixel is unsigned, weight is signed
  always_comb begin
    for (int i = 0; i < conv_row_pkg::taps; i++) begin
      prod[i] = $signed({1'b0, win_pixels[i*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w]})
              * $signed(kernel_q[i*conv_row_pkg::weight_w +: conv_row_pkg::weight_w]);
    end
  end

  // first level, one partial sum per window row
  always_comb begin
    for (int r = 0; r < conv_row_pkg::row_count; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < conv_row_pkg::row_count; c++) begin
        row_sum[r] = row_sum[r] + prod[r*conv_row_pkg::row_count + c];
      end
    end
  end

  // second level
  assign total = row_sum[0] + row_sum[1] + row_sum[2];

  // one cycle from issue to result
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= win_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      out_sum <= total;
    end
  end

endmodule

// ==== hdl/conv_row_pkg.sv ====
package conv_row_pkg;

  ////////////////////////////////////////
  // pixel and row register geometry
  ////////////////////////////////////////

  localparam int pixel_w = 8;
  localparam int reg_pixels = 16;
  localparam int seg_pixels = 8;
  localparam int slab_pixels = 2;
  // rows per window, also columns per window
  localparam int row_count = 3;

  localparam int reg_w = reg_pixels * pixel_w;
  localparam int seg_w = seg_pixels * pixel_w;
  localparam int slab_w = slab_pixels * pixel_w;

  // command descriptor widths
  localparam int idx_w = 5;
  localparam int pad_w = 3;

  ////////////////////////////////////////
  // window and kernel
  ////////////////////////////////////////

  localparam int win_count = reg_pixels - 2;
  localparam int col_w = $clog2(win_count);
  localparam int taps = row_count * row_count;
  localparam int win_w = taps * pixel_w;
  localparam int weight_w = 8;
  localparam int kernel_w = taps * weight_w;
  // unsigned pixel gets a sign bit before the multiply
  localparam int prod_w = pixel_w + 1 + weight_w;
  localparam int sum_w = 20;

  // flow control
  localparam int cmd_credits = 1;
  localparam int out_credits_max = 8;
  localparam int credit_w = $clog2(out_credits_max + 1);

endpackage

// ==== hdl/conv_row_top.sv ====
`timescale 1ns/1ps

module conv_row_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cmd_valid,
  input  logic [conv_row_pkg::idx_w-1:0]        start_idx,
  input  logic [conv_row_pkg::idx_w-1:0]        end_idx,
  input  logic [conv_row_pkg::pad_w-1:0]        west_pad,
  input  logic [conv_row_pkg::pad_w-1:0]        east_pad,
  input  logic [conv_row_pkg::pad_w-1:0]        slab_num,
  input  logic [conv_row_pkg::seg_w-1:0]        row1_seg,
  input  logic [conv_row_pkg::seg_w-1:0]        row2_seg,
  input  logic [conv_row_pkg::seg_w-1:0]        row3_seg,
  input  logic [conv_row_pkg::slab_w-1:0]       row1_slab,
  input  logic [conv_row_pkg::slab_w-1:0]       row2_slab,
  input  logic [conv_row_pkg::slab_w-1:0]       row3_slab,
  input  logic [conv_row_pkg::row_count-1:0]    row_valid,
  input  logic [conv_row_pkg::kernel_w-1:0]     kernel,
  input  logic                                  out_credit,
  output logic                                  cmd_credit,
  output logic                                  out_valid,
  output logic signed [conv_row_pkg::sum_w-1:0] out_sum
);

  // fill to window stage
  logic [conv_row_pkg::reg_w-1:0] row_regs_1;
  logic [conv_row_pkg::reg_w-1:0] row_regs_2;
  logic [conv_row_pkg::reg_w-1:0] row_regs_3;
  logic                           fill_done;
  // window stage to mac
  logic                           win_valid;
  logic [conv_row_pkg::win_w-1:0] win_pixels;

  row_regs_fill u_row_regs_fill (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .start_idx  (start_idx),
    .end_idx    (end_idx),
    .west_pad   (west_pad),
    .east_pad   (east_pad),
    .slab_num   (slab_num),
    .row1_seg   (row1_seg),
    .row2_seg   (row2_seg),
    .row3_seg   (row3_seg),
    .row1_slab  (row1_slab),
    .row2_slab  (row2_slab),
    .row3_slab  (row3_slab),
    .row_valid  (row_valid),
    .row_regs_1 (row_regs_1),
    .row_regs_2 (row_regs_2),
    .row_regs_3 (row_regs_3),
    .fill_done  (fill_done)
  );

  window_shift u_window_shift (
    .clk        (clk),
    .reset      (reset),
    .fill_done  (fill_done),
    .row_regs_1 (row_regs_1),
    .row_regs_2 (row_regs_2),
    .row_regs_3 (row_regs_3),
    .out_credit (out_credit),
    .win_valid  (win_valid),
    .win_pixels (win_pixels),
    .cmd_credit (cmd_credit)
  );

  conv_mac u_conv_mac (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .kernel     (kernel),
    .win_valid  (win_valid),
    .win_pixels (win_pixels),
    .out_valid  (out_valid),
    .out_sum    (out_sum)
  );

endmodule

// ==== hdl/row_regs_fill.sv ====
`timescale 1ns/1ps

module row_regs_fill (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cmd_valid,
  input  logic [conv_row_pkg::idx_w-1:0]        start_idx,
  input  logic [conv_row_pkg::idx_w-1:0]        end_idx,
  input  logic [conv_row_pkg::pad_w-1:0]        west_pad,
  input  logic [conv_row_pkg::pad_w-1:0]        east_pad,
  input  logic [conv_row_pkg::pad_w-1:0]        slab_num,
  input  logic [conv_row_pkg::seg_w-1:0]        row1_seg,
  input  logic [conv_row_pkg::seg_w-1:0]        row2_seg,
  input  logic [conv_row_pkg::seg_w-1:0]        row3_seg,
  input  logic [conv_row_pkg::slab_w-1:0]       row1_slab,
  input  logic [conv_row_pkg::slab_w-1:0]       row2_slab,
  input  logic [conv_row_pkg::slab_w-1:0]       row3_slab,
  input  logic [conv_row_pkg::row_count-1:0]    row_valid,
  output logic [conv_row_pkg::reg_w-1:0]        row_regs_1,
  output logic [conv_row_pkg::reg_w-1:0]        row_regs_2,
  output logic [conv_row_pkg::reg_w-1:0]        row_regs_3,
  output logic                                  fill_done
);

  // command fields gathered per row
  logic [conv_row_pkg::reg_w-1:0]   seg_in  [conv_row_pkg::row_count];
  logic [conv_row_pkg::slab_w-1:0]  slab_in [conv_row_pkg::row_count];
  logic [conv_row_pkg::idx_w-1:0]   seg_base;
  logic [conv_row_pkg::idx_w-1:0]   slab_ext;
  logic [conv_row_pkg::idx_w-1:0]   west_ext;
  logic [conv_row_pkg::idx_w-1:0]   east_ext;
  logic [conv_row_pkg::idx_w-1:0]   lo_in;
  logic [conv_row_pkg::idx_w-1:0]   hi_in;

  // stage one
  logic [conv_row_pkg::reg_w-1:0]     s1_seg  [conv_row_pkg::row_count];
  logic [conv_row_pkg::slab_w-1:0]    s1_slab [conv_row_pkg::row_count];
  logic [conv_row_pkg::idx_w-1:0]     s1_lo;
  logic [conv_row_pkg::idx_w-1:0]     s1_hi;
  logic [conv_row_pkg::idx_w-1:0]     s1_end;
  logic [conv_row_pkg::pad_w-1:0]     s1_slab_num;
  logic [conv_row_pkg::row_count-1:0] s1_row_valid;
  logic                               s1_go;

  // stage two
  logic [conv_row_pkg::reg_w-1:0]      fill_d  [conv_row_pkg::row_count];
  logic [conv_row_pkg::reg_pixels-1:0] load_d;
  logic [conv_row_pkg::reg_w-1:0]      s2_fill [conv_row_pkg::row_count];
  logic [conv_row_pkg::reg_pixels-1:0] s2_load;
  logic [conv_row_pkg::row_count-1:0]  s2_row_valid;
  logic                                s2_go;

  // stage three, the row registers
  logic [conv_row_pkg::reg_w-1:0] row_q [conv_row_pkg::row_count];

  ////////////////////////////////////////
  // stage one: shift segments, bounds
  ////////////////////////////////////////

  // segments zero extended to register width
  assign seg_in[0] = {{(conv_row_pkg::reg_w - conv_row_pkg::seg_w){1'b0}}, row1_seg};
  assign seg_in[1] = {{(conv_row_pkg::reg_w - conv_row_pkg::seg_w){1'b0}}, row2_seg};
  assign seg_in[2] = {{(conv_row_pkg::reg_w - conv_row_pkg::seg_w){1'b0}}, row3_seg};
  assign slab_in[0] = row1_slab;
  assign slab_in[1] = row2_slab;
  assign slab_in[2] = row3_slab;

  assign slab_ext = {{(conv_row_pkg::idx_w - conv_row_pkg::pad_w){1'b0}}, slab_num};
  assign west_ext = {{(conv_row_pkg::idx_w - conv_row_pkg::pad_w){1'b0}}, west_pad};
  assign east_ext = {{(conv_row_pkg::idx_w - conv_row_pkg::pad_w){1'b0}}, east_pad};

  // first segment pixel lands at start_idx - 1
  assign seg_base = start_idx - 1'b1;
  // load window lo..hi, slab and padding included
  assign lo_in = start_idx - 1'b1 - slab_ext - west_ext;
  assign hi_in = end_idx - 1'b1 + east_ext;

  always_ff @(posedge clk) begin
    for (int r = 0; r < conv_row_pkg::row_count; r++) begin
      s1_seg[r]  <= seg_in[r] << (seg_base * conv_row_pkg::pixel_w);
      s1_slab[r] <= slab_in[r];
    end
    s1_lo        <= lo_in;
    s1_hi        <= hi_in;
    s1_end       <= end_idx;
    s1_slab_num  <= slab_num;
    s1_row_valid <= row_valid;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_go <= 1'b0;
    end else begin
      s1_go <= cmd_valid;
    end
  end

  ////////////////////////////////////////
  // stage two: fill data and load mask
  ////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < conv_row_pkg::reg_pixels; p++) begin
      // inside lo..hi the position loads, outside it clears
      load_d[p] = (p >= int'(s1_lo)) && (p <= int'(s1_hi));
      for (int r = 0; r < conv_row_pkg::row_count; r++) begin
        // segment pixels end at end_idx - 1
        if (p < int'(s1_end)) begin
          fill_d[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w] =
            s1_seg[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w];
        end else begin
          fill_d[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w] = '0;
        end
        // slab at the left edge
        // a single slab pixel is the upper one
        if ((p < int'(s1_slab_num)) && (int'(s1_slab_num) <= conv_row_pkg::slab_pixels)) begin
          fill_d[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w] =
            s1_slab[r][(conv_row_pkg::slab_pixels - int'(s1_slab_num) + p)
                       * conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < conv_row_pkg::row_count; r++) begin
      s2_fill[r] <= fill_d[r];
    end
    s2_load      <= load_d;
    s2_row_valid <= s1_row_valid;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_go <= 1'b0;
    end else begin
      s2_go <= s1_go;
    end
  end

  ////////////////////////////////////////
  // stage three: write row registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_done <= 1'b0;
      for (int r = 0; r < conv_row_pkg::row_count; r++) begin
        row_q[r] <= '0;
      end
    end else begin
      fill_done <= s2_go;
      for (int r = 0; r < conv_row_pkg::row_count; r++) begin
        // invalid row keeps the previous load
        if (s2_go && s2_row_valid[r]) begin
          for (int p = 0; p < conv_row_pkg::reg_pixels; p++) begin
            row_q[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w] <= s2_load[p] ?
              s2_fill[r][p*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w] : '0;
          end
        end
      end
    end
  end

  assign row_regs_1 = row_q[0];
  assign row_regs_2 = row_q[1];
  assign row_regs_3 = row_q[2];

endmodule

// ==== hdl/window_shift.sv ====
`timescale 1ns/1ps

module window_shift (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             fill_done,
  input  logic [conv_row_pkg::reg_w-1:0]   row_regs_1,
  input  logic [conv_row_pkg::reg_w-1:0]   row_regs_2,
  input  logic [conv_row_pkg::reg_w-1:0]   row_regs_3,
  input  logic                             out_credit,
  output logic                             win_valid,
  output logic [conv_row_pkg::win_w-1:0]   win_pixels,
  output logic                             cmd_credit
);

  // private copy of the rows for the whole walk
  logic [conv_row_pkg::reg_w-1:0]    cap [conv_row_pkg::row_count];
  logic [conv_row_pkg::col_w-1:0]    col;
  logic                              active;
  logic                              last_col;
  logic [conv_row_pkg::credit_w-1:0] credit_cnt;

  ////////////////////////////////////////
  // issue control
  ////////////////////////////////////////

  // issue needs a loaded window and one output credit
  assign win_valid  = active && (credit_cnt != '0);
  assign last_col   = (int'(col) == conv_row_pkg::win_count - 1);
  // last window frees the command slot
  assign cmd_credit = win_valid && last_col;

  always_ff @(posedge clk) begin
    if (fill_done) begin
      cap[0] <= row_regs_1;
      cap[1] <= row_regs_2;
      cap[2] <= row_regs_3;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      col    <= '0;
    end else if (fill_done) begin
      active <= 1'b1;
      col    <= '0;
    end else if (win_valid) begin
      if (last_col) begin
        // walk done, wait for next load
        active <= 1'b0;
        col    <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // grant and issue in one cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= '0;
    end else if (out_credit && !win_valid) begin
      credit_cnt <= credit_cnt + 1'b1;
    end else if (!out_credit && win_valid) begin
      credit_cnt <= credit_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////
  // window select
  ////////////////////////////////////////

  // tap r*3+c is row r, column col+c
  always_comb begin
    for (int r = 0; r < conv_row_pkg::row_count; r++) begin
      for (int c = 0; c < conv_row_pkg::row_count; c++) begin
        win_pixels[(r*conv_row_pkg::row_count + c)*conv_row_pkg::pixel_w +:
                   conv_row_pkg::pixel_w] =
          cap[r][(int'(col) + c)*conv_row_pkg::pixel_w +: conv_row_pkg::pixel_w];
      end
    end
  end

endmodule

// ==== tests/conv_row_tests.hex ====
// per test: name start end west_pad east_pad slab_num row_valid credit_mode,
// then row1..3 segments, row1..3 slabs, kernel w0..w8, 14 expected sums (20 bit)
0 1 8 0 0 0 7 0
0807060504030201 0202020202020202 0303030303030303
0 0 0
01 01 01 ff ff ff 00 02 00
6 9 c f 12 15 11
6 0 0 0 0 0 0
1 4 8 1 2 2 7 0
3837363534333231 5857565554535251 0
2221 4241 0
01 00 00 00 00 00 00 00 00
21 22 0 31 32 33 34
35 0 0 0 0 0 0
2 2 5 0 3 1 5 0
1111111111111111 2222222222222222 3333333333333333
1111 2222 3333
00 00 00 00 ff 00 00 00 00
fffbe 0 fffaf fffae fffad fffac fffab
0 0 0 0 0 0 0
3 2 5 0 3 1 7 1
7877767574737271 0 0
6261 0 0
01 00 00 00 00 00 00 00 00
62 71 72 73 74 0 0
0 0 0 0 0 0 0

// ==== tests/tb_conv_row.sv ====
`timescale 1ns/1ps

module tb_conv_row;

  localparam int num_tests = 4;
  localparam int words = 37;
  localparam int timeout_limit = num_tests * (conv_row_pkg::win_count + 10) * 4;

  logic clk;
  logic reset;
  logic cmd_valid;
  logic [conv_row_pkg::idx_w-1:0] start_idx;
  logic [conv_row_pkg::idx_w-1:0] end_idx;
  logic [conv_row_pkg::pad_w-1:0] west_pad;
  logic [conv_row_pkg::pad_w-1:0] east_pad;
  logic [conv_row_pkg::pad_w-1:0] slab_num;
  logic [conv_row_pkg::seg_w-1:0] row1_seg;
  logic [conv_row_pkg::seg_w-1:0] row2_seg;
  logic [conv_row_pkg::seg_w-1:0] row3_seg;
  logic [conv_row_pkg::slab_w-1:0] row1_slab;
  logic [conv_row_pkg::slab_w-1:0] row2_slab;
  logic [conv_row_pkg::slab_w-1:0] row3_slab;
  logic [conv_row_pkg::row_count-1:0] row_valid;
  logic [conv_row_pkg::kernel_w-1:0] kernel;
  logic out_credit;
  logic cmd_credit;
  logic out_valid;
  logic signed [conv_row_pkg::sum_w-1:0] out_sum;

  logic [63:0] test_mem [0:num_tests*words-1];
  string test_names [num_tests] = '{"plain_load", "west_pad_slab2", "invalid_row",
                                    "slab1_backpressure"};
  // reference copy of the row registers, kept across loads
  int model_rows [3][16];
  int exp_sums [conv_row_pkg::win_count];
  int cycle = 0;
  int cmd_cycle;
  int cur_test;
  int cur_mode;
  int recv;
  int granted;
  int pending_cmd = 0;
  int src_credits = conv_row_pkg::cmd_credits;
  int credit_pulses = 0;
  int seed = 32'h8b33;

  conv_row_top u_conv_row_top (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid),
    .start_idx(start_idx), .end_idx(end_idx),
    .west_pad(west_pad), .east_pad(east_pad), .slab_num(slab_num),
    .row1_seg(row1_seg), .row2_seg(row2_seg), .row3_seg(row3_seg),
    .row1_slab(row1_slab), .row2_slab(row2_slab), .row3_slab(row3_slab),
    .row_valid(row_valid), .kernel(kernel), .out_credit(out_credit),
    .cmd_credit(cmd_credit), .out_valid(out_valid), .out_sum(out_sum)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected !== actual) begin
      report_failure($sformatf("mismatch %s: expected %0d, actual %0d", what, expected,
                               actual));
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= timeout_limit) begin
      report_failure("run timed out waiting for the DUT");
    end
  end

  // sum and credit monitor, sampled mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (out_valid) begin
        if (recv >= conv_row_pkg::win_count) begin
          report_failure("more sums than windows for one command");
        end else begin
          check_value($sformatf("%s sum %0d", test_names[cur_test], recv), exp_sums[recv],
                      int'(out_sum));
          if (recv == 0 && cur_mode == 0) begin
            check_value($sformatf("%s first sum latency", test_names[cur_test]), 5,
                        cycle - cmd_cycle);
          end
          recv = recv + 1;
          if (recv > granted) begin
            report_failure("sum issued without an output credit");
          end
        end
      end
      if (cmd_credit) begin
        if (pending_cmd == 0) begin
          report_failure("command credit returned with no command outstanding");
        end
        pending_cmd = 0;
        src_credits = src_credits + 1;
        credit_pulses = credit_pulses + 1;
      end
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // fill rule, then window rule, for test t
  task automatic build_model(input int t);
    int b;
    int st;
    int en;
    int sl;
    int lo;
    int hi;
    int pix;
    int w;
    int acc;
    b = t * words;
    // block order in the file
    check_value($sformatf("%s name index", test_names[t]), t, int'(test_mem[b]));
    st = int'(test_mem[b+1]);
    en = int'(test_mem[b+2]);
    sl = int'(test_mem[b+5]);
    lo = st - 1 - sl - int'(test_mem[b+3]);
    hi = en - 1 + int'(test_mem[b+4]);
    for (int r = 0; r < 3; r++) begin
      if (test_mem[b+6][r]) begin
        for (int p = 0; p < 16; p++) begin
          pix = 0;
          if (p >= lo && p <= hi) begin
            if (p >= st - 1 && p <= en - 1) begin
              pix = int'(test_mem[b+8+r][(p-st+1)*8 +: 8]);
            end else if (sl == 2 && p < 2) begin
              pix = int'(test_mem[b+11+r][p*8 +: 8]);
            end else if (sl == 1 && p == 0) begin
              pix = int'(test_mem[b+11+r][15:8]);
            end
          end
          model_rows[r][p] = pix;
        end
      end
    end
    for (int k = 0; k < conv_row_pkg::win_count; k++) begin
      acc = 0;
      for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
          w = int'($signed(test_mem[b+14+r*3+c][7:0]));
          acc = acc + model_rows[r][k+c] * w;
        end
      end
      exp_sums[k] = int'($signed(test_mem[b+23+k][19:0]));
      check_value($sformatf("%s file sum %0d", test_names[t], k), acc, exp_sums[k]);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic run_test(input int t);
    int b;
    int gap;
    b = t * words;
    gap = 0;
    cur_test = t;
    cur_mode = int'(test_mem[b+7]);
    recv = 0;
    granted = 0;
    build_model(t);
    // mode 0 grants credits up front
    if (cur_mode == 0) begin
      repeat (conv_row_pkg::out_credits_max) begin
        @(posedge clk);
        #2;
        out_credit = 1'b1;
        granted = granted + 1;
      end
      @(posedge clk);
      #2;
      out_credit = 1'b0;
    end
    // source sends only while it holds a command credit
    while (src_credits == 0) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    start_idx = test_mem[b+1][4:0];
    end_idx = test_mem[b+2][4:0];
    west_pad = test_mem[b+3][2:0];
    east_pad = test_mem[b+4][2:0];
    slab_num = test_mem[b+5][2:0];
    row_valid = test_mem[b+6][2:0];
    row1_seg = test_mem[b+8];
    row2_seg = test_mem[b+9];
    row3_seg = test_mem[b+10];
    row1_slab = test_mem[b+11][15:0];
    row2_slab = test_mem[b+12][15:0];
    row3_slab = test_mem[b+13][15:0];
    for (int i = 0; i < 9; i++) begin
      kernel[i*8 +: 8] = test_mem[b+14+i][7:0];
    end
    cmd_valid = 1'b1;
    cmd_cycle = cycle;
    pending_cmd = 1;
    src_credits = src_credits - 1;
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
    // sink never holds more than out_credits_max unspent
    while (recv < conv_row_pkg::win_count) begin
      out_credit = 1'b0;
      if (gap > 0) begin
        gap = gap - 1;
      end else if (granted < conv_row_pkg::win_count &&
                   granted - recv < conv_row_pkg::out_credits_max) begin
        out_credit = 1'b1;
        granted = granted + 1;
        if (cur_mode == 1) begin
          gap = $unsigned($random(seed)) % 4;
        end
      end
      @(posedge clk);
      #2;
    end
    out_credit = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    // credit returns with the last window, one pulse per command
    check_value($sformatf("%s cmd credit pulses", test_names[t]), t + 1, credit_pulses);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    start_idx = '0;
    end_idx = '0;
    west_pad = '0;
    east_pad = '0;
    slab_num = '0;
    row1_seg = '0;
    row2_seg = '0;
    row3_seg = '0;
    row1_slab = '0;
    row2_slab = '0;
    row3_slab = '0;
    row_valid = '0;
    kernel = '0;
    out_credit = 1'b0;
    recv = 0;
    granted = 0;
    cur_test = 0;
    cur_mode = 0;
    cmd_cycle = 0;
    $readmemh("tests/conv_row_tests.hex", test_mem);
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    // idle outputs before any command
    repeat (4) begin
      @(negedge clk);
      check_value("reset out_valid", 0, int'(out_valid));
      check_value("reset cmd_credit", 0, int'(cmd_credit));
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/conv_row_pkg.sv
hdl/row_regs_fill.sv
hdl/window_shift.sv
hdl/conv_mac.sv
hdl/conv_row_top.sv
tests/tb_conv_row.sv
